// ==== Bender.yml ====
package:
  name: usb_rx

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/usb_rx_pkg.sv
      - hdl/usb_bit_if.sv
      - hdl/usb_crc.sv
      - hdl/usb_line_decoder.sv
      - hdl/usb_packet_decoder.sv
      - hdl/usb_rx.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_usb_rx.sv

// ==== hdl/usb_bit_if.sv ====
`default_nettype none

// decoded bit stream between line decoder and packet decoder
interface usb_bit_if;

  // one pulse per received bit, stuffed zeros removed
  logic bit_valid;
  // decoded value, good only with bit_valid
  logic bit_value;
  // first k after idle, ahead of the first bit
  logic sop;
  // end of packet, se0 then j seen
  logic eop;
  // seventh one in a row on the line
  logic stuff_error;

  // line decoder side
  modport source (
    output bit_valid, bit_value, sop, eop, stuff_error
  );

  // packet decoder side
  modport sink (
    input bit_valid, bit_value, sop, eop, stuff_error
  );

endinterface

`default_nettype wire

// ==== hdl/usb_crc.sv ====
`default_nettype none

`include "usb_rx_defs.svh"

// serial crc checker, bits in wire order
module usb_crc #(
  parameter int WIDTH = 5,
  parameter logic [WIDTH-1:0] POLY = '0
) (
  input wire tb_clk,
  input wire arst_n,
  input wire clear,
  input wire shift,
  input wire data,
  output logic residue_ok
);

  // residue picked by register width
  localparam logic [WIDTH-1:0] residue = (WIDTH == 5) ?
    WIDTH'(`USB_RX_CRC5_RESIDUE) : WIDTH'(`USB_RX_CRC16_RESIDUE);

  logic [WIDTH-1:0] crc_q;
  logic feedback;

  // incoming bit against top of register
  assign feedback = data ^ crc_q[WIDTH-1];

  // ******************************
  // galois register
  // ******************************

  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      crc_q <= '1;
    end else if (clear) begin
      // preset all ones per packet
      crc_q <= '1;
    end else if (shift) begin
      crc_q <= {crc_q[WIDTH-2:0], 1'b0} ^ (feedback ? POLY : '0);
    end
  end

  // good once the whole packet plus its crc went through
  assign residue_ok = (crc_q == residue);

endmodule

`default_nettype wire

// ==== hdl/usb_line_decoder.sv ====
`default_nettype none

`include "usb_rx_defs.svh"

module usb_line_decoder (
  input wire tb_clk,
  input wire arst_n,
  input wire d_plus,
  input wire d_minus,
  usb_bit_if.source bits
);

  localparam int cnt_w = $clog2(`USB_RX_OVERSAMPLE);
  // mid-bit, counted from the last seen edge
  localparam logic [cnt_w-1:0] sample_at = cnt_w'(`USB_RX_OVERSAMPLE / 2 - 1);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`USB_RX_OVERSAMPLE - 1);

  logic dp_meta;
  logic dp_sync;
  logic dp_prev;
  logic dm_meta;
  logic dm_sync;
  logic dm_prev;
  logic line_edge;
  logic line_j;
  logic line_k;
  logic line_se0;
  logic sample;
  logic nrzi_bit;
  logic last_level;
  logic [cnt_w-1:0] phase_cnt;
  logic [2:0] ones_cnt;
  logic [1:0] se0_cnt;
  usb_rx_pkg::line_state_t state;

  // ******************************
  // synchronizer
  // ******************************

  // two flops per line, idle j on reset
  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      dp_meta <= 1'b1;
      dp_sync <= 1'b1;
      dp_prev <= 1'b1;
      dm_meta <= 1'b0;
      dm_sync <= 1'b0;
      dm_prev <= 1'b0;
    end else begin
      dp_meta <= d_plus;
      dp_sync <= dp_meta;
      dp_prev <= dp_sync;
      dm_meta <= d_minus;
      dm_sync <= dm_meta;
      dm_prev <= dm_sync;
    end
  end

  // any change on either line
  assign line_edge = (dp_sync != dp_prev) || (dm_sync != dm_prev);

  // line states
  assign line_j = dp_sync & ~dm_sync;
  assign line_k = ~dp_sync & dm_sync;
  assign line_se0 = ~dp_sync & ~dm_sync;

  // ******************************
  // bit timing
  // ******************************

  // restarts on every edge, free runs over long runs of ones
  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      phase_cnt <= '0;
    end else if (line_edge || phase_cnt == cnt_last) begin
      phase_cnt <= '0;
    end else begin
      phase_cnt <= phase_cnt + 1'b1;
    end
  end

  assign sample = !line_edge && (phase_cnt == sample_at);

  // nrzi, no change from last bit means one
  assign nrzi_bit = (dp_sync == last_level);

  // ******************************
  // receive fsm
  // ******************************

  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= usb_rx_pkg::LINE_IDLE;
      last_level <= 1'b1;
      ones_cnt <= '0;
      se0_cnt <= '0;
      bits.bit_valid <= 1'b0;
      bits.bit_value <= 1'b0;
      bits.sop <= 1'b0;
      bits.eop <= 1'b0;
      bits.stuff_error <= 1'b0;
    end else begin
      // pulses by default
      bits.bit_valid <= 1'b0;
      bits.sop <= 1'b0;
      bits.eop <= 1'b0;
      bits.stuff_error <= 1'b0;
      case (state)
        usb_rx_pkg::LINE_IDLE: begin
          // first k ends idle, sync starts here
          if (line_edge && line_k) begin
            bits.sop <= 1'b1;
            last_level <= 1'b1;
            ones_cnt <= '0;
            state <= usb_rx_pkg::LINE_RECEIVE;
          end
        end
        usb_rx_pkg::LINE_RECEIVE: begin
          if (sample) begin
            if (line_se0) begin
              se0_cnt <= 2'd1;
              state <= usb_rx_pkg::LINE_EOP;
            end else begin
              last_level <= dp_sync;
              if (ones_cnt == 3'd6) begin
                // stuffed zero expected, a one is a violation
                ones_cnt <= '0;
                bits.stuff_error <= nrzi_bit;
              end else begin
                bits.bit_valid <= 1'b1;
                bits.bit_value <= nrzi_bit;
                ones_cnt <= nrzi_bit ? ones_cnt + 3'd1 : 3'd0;
              end
            end
          end
        end
        usb_rx_pkg::LINE_EOP: begin
          if (sample) begin
            if (line_se0) begin
              // saturate at two bit times
              if (se0_cnt != 2'd2) begin
                se0_cnt <= se0_cnt + 2'd1;
              end
            end else begin
              // short se0 or k here is a glitch, just drop back
              bits.eop <= line_j && (se0_cnt == 2'd2);
              state <= usb_rx_pkg::LINE_IDLE;
            end
          end
        end
        default: state <= usb_rx_pkg::LINE_IDLE;
      endcase
    end
  end

  // eop stands alone, no decoded bit in the cycle before either
  a_eop_apart: assert property (@(posedge tb_clk) disable iff (!arst_n)
    bits.eop |-> !bits.bit_valid && !$past(bits.bit_valid));

endmodule

`default_nettype wire

// ==== hdl/usb_packet_decoder.sv ====
`default_nettype none

`include "usb_rx_defs.svh"

module usb_packet_decoder (
  input wire tb_clk,
  input wire arst_n,
  usb_bit_if.sink bits,
  output usb_rx_pkg::rx_packet_t rx_packet,
  output logic store_rx_packet_data,
  output usb_rx_pkg::byte_t rx_packet_data
);

  // payload plus two crc bytes must fit
  localparam int cnt_w = $clog2(`USB_RX_MAX_PAYLOAD + 3);
  localparam logic [cnt_w-1:0] max_bytes = cnt_w'(`USB_RX_MAX_PAYLOAD + 2);
  localparam logic [cnt_w-1:0] crc_bytes = cnt_w'(2);

  usb_rx_pkg::pkt_state_t state;
  usb_rx_pkg::byte_t shift_q;
  usb_rx_pkg::byte_t next_byte;
  usb_rx_pkg::byte_t hold_0;
  usb_rx_pkg::byte_t hold_1;
  usb_rx_pkg::pid_t pid_q;
  usb_rx_pkg::rx_packet_t verdict;
  logic [2:0] bit_cnt;
  logic [cnt_w-1:0] byte_cnt;
  logic [1:0] hold_cnt;
  logic byte_done;
  logic pid_ok;
  logic whole_bytes;
  logic crc5_shift;
  logic crc16_shift;
  logic crc5_ok;
  logic crc16_ok;

  // lsb first, new bit enters at the top
  assign next_byte = {bits.bit_value, shift_q[7:1]};
  assign byte_done = bits.bit_valid && (bit_cnt == 3'd7);
  assign whole_bytes = (bit_cnt == 3'd0);

  // upper nibble must be the complement of the pid
  assign pid_ok = (next_byte[7:4] == ~next_byte[3:0]);

  // ******************************
  // crc checkers
  // ******************************

  // token crc covers address, endpoint and crc5
  assign crc5_shift = bits.bit_valid && (state == usb_rx_pkg::ST_TOKEN);
  // data crc covers payload and crc16
  assign crc16_shift = bits.bit_valid && (state == usb_rx_pkg::ST_PAYLOAD);

  usb_crc #(
    .WIDTH($bits(usb_rx_pkg::crc5_t)),
    .POLY(usb_rx_pkg::CRC5_POLY)
  ) i_crc5 (
    .tb_clk(tb_clk),
    .arst_n(arst_n),
    .clear(bits.sop),
    .shift(crc5_shift),
    .data(bits.bit_value),
    .residue_ok(crc5_ok)
  );

  usb_crc #(
    .WIDTH($bits(usb_rx_pkg::crc16_t)),
    .POLY(usb_rx_pkg::CRC16_POLY)
  ) i_crc16 (
    .tb_clk(tb_clk),
    .arst_n(arst_n),
    .clear(bits.sop),
    .shift(crc16_shift),
    .data(bits.bit_value),
    .residue_ok(crc16_ok)
  );

  // ******************************
  // class at eop
  // ******************************

  always_comb begin
    verdict = usb_rx_pkg::RX_BAD;
    case (state)
      usb_rx_pkg::ST_TOKEN: begin
        // exactly two bytes and a clean crc5
        if (whole_bytes && byte_cnt == crc_bytes && crc5_ok) begin
          verdict = (pid_q == usb_rx_pkg::PID_IN) ? usb_rx_pkg::RX_IN : usb_rx_pkg::RX_OUT;
        end
      end
      usb_rx_pkg::ST_PAYLOAD: begin
        // overlong payloads already went to error
        if (whole_bytes && byte_cnt >= crc_bytes && crc16_ok) begin
          verdict = usb_rx_pkg::RX_DATA;
        end
      end
      usb_rx_pkg::ST_HANDSHAKE: begin
        verdict = (pid_q == usb_rx_pkg::PID_ACK) ? usb_rx_pkg::RX_ACK : usb_rx_pkg::RX_NAK;
      end
      default: verdict = usb_rx_pkg::RX_BAD;
    endcase
  end

  // ******************************
  // packet fsm
  // ******************************

  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= usb_rx_pkg::ST_HUNT;
      bit_cnt <= '0;
      byte_cnt <= '0;
      hold_cnt <= '0;
      rx_packet <= usb_rx_pkg::RX_IDLE;
      store_rx_packet_data <= 1'b0;
      rx_packet_data <= '0;
    end else begin
      store_rx_packet_data <= 1'b0;
      if (bits.sop) begin
        // restart, also after an aborted packet
        state <= usb_rx_pkg::ST_SYNC;
        bit_cnt <= '0;
        byte_cnt <= '0;
        hold_cnt <= '0;
      end else if (bits.eop) begin
        if (state != usb_rx_pkg::ST_HUNT && state != usb_rx_pkg::ST_DONE) begin
          rx_packet <= verdict;
          state <= usb_rx_pkg::ST_DONE;
        end
      end else if (bits.stuff_error && state != usb_rx_pkg::ST_HUNT &&
                   state != usb_rx_pkg::ST_DONE) begin
        state <= usb_rx_pkg::ST_ERROR;
      end else if (bits.bit_valid) begin
        bit_cnt <= bit_cnt + 3'd1;
        case (state)
          usb_rx_pkg::ST_SYNC: begin
            if (byte_done) begin
              state <= (next_byte == usb_rx_pkg::SYNC_BYTE) ?
                usb_rx_pkg::ST_PID : usb_rx_pkg::ST_ERROR;
            end
          end
          usb_rx_pkg::ST_PID: begin
            if (byte_done && !pid_ok) begin
              state <= usb_rx_pkg::ST_ERROR;
            end else if (byte_done) begin
              case (next_byte[3:0])
                usb_rx_pkg::PID_OUT,
                usb_rx_pkg::PID_IN: state <= usb_rx_pkg::ST_TOKEN;
                usb_rx_pkg::PID_DATA0,
                usb_rx_pkg::PID_DATA1: state <= usb_rx_pkg::ST_PAYLOAD;
                usb_rx_pkg::PID_ACK,
                usb_rx_pkg::PID_NAK: state <= usb_rx_pkg::ST_HANDSHAKE;
                // stall, setup, sof and the rest
                default: state <= usb_rx_pkg::ST_ERROR;
              endcase
            end
          end
          usb_rx_pkg::ST_TOKEN: begin
            if (byte_done && byte_cnt == crc_bytes) begin
              state <= usb_rx_pkg::ST_ERROR;
            end else if (byte_done) begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
          usb_rx_pkg::ST_PAYLOAD: begin
            if (byte_done && byte_cnt == max_bytes) begin
              state <= usb_rx_pkg::ST_ERROR;
            end else if (byte_done) begin
              byte_cnt <= byte_cnt + 1'b1;
              // pipe full, oldest byte is now known not to be crc
              if (hold_cnt == 2'd2) begin
                store_rx_packet_data <= 1'b1;
                rx_packet_data <= hold_0;
              end else begin
                hold_cnt <= hold_cnt + 2'd1;
              end
            end
          end
          // any bit after a handshake pid is too many
          usb_rx_pkg::ST_HANDSHAKE: state <= usb_rx_pkg::ST_ERROR;
          default: ;
        endcase
      end else if (state == usb_rx_pkg::ST_DONE) begin
        // the two crc bytes left in the pipe are dropped
        hold_cnt <= '0;
        state <= usb_rx_pkg::ST_HUNT;
      end
    end
  end

  // ******************************
  // byte path
  // ******************************

  always_ff @(posedge tb_clk) begin
    if (bits.bit_valid) begin
      shift_q <= next_byte;
    end
    if (byte_done && state == usb_rx_pkg::ST_PID) begin
      pid_q <= next_byte[3:0];
    end
    // two-entry holding pipe, hold_0 is the older
    if (byte_done && state == usb_rx_pkg::ST_PAYLOAD) begin
      case (hold_cnt)
        2'd0: hold_0 <= next_byte;
        2'd1: hold_1 <= next_byte;
        default: begin
          hold_0 <= hold_1;
          hold_1 <= next_byte;
        end
      endcase
    end
  end

  // strobe only inside a data packet, right after a completed byte
  a_store_in_payload: assert property (@(posedge tb_clk) disable iff (!arst_n)
    store_rx_packet_data |-> (state == usb_rx_pkg::ST_PAYLOAD) && $past(bits.bit_valid));

endmodule

`default_nettype wire

// ==== hdl/usb_rx.sv ====
`default_nettype none

// full-speed style receiver for one downstream port
module usb_rx (
  input wire tb_clk,
  input wire arst_n,
  input wire d_plus,
  input wire d_minus,
  output usb_rx_pkg::rx_packet_t rx_packet,
  output logic store_rx_packet_data,
  output usb_rx_pkg::byte_t rx_packet_data
);

  // decoded bit stream
  usb_bit_if bits ();

  // ******************************
  // line side
  // ******************************

  usb_line_decoder i_line_decoder (
    .tb_clk(tb_clk),
    .arst_n(arst_n),
    .d_plus(d_plus),
    .d_minus(d_minus),
    .bits(bits.source)
  );

  // ******************************
  // packet side
  // ******************************

  usb_packet_decoder i_packet_decoder (
    .tb_clk(tb_clk),
    .arst_n(arst_n),
    .bits(bits.sink),
    .rx_packet(rx_packet),
    .store_rx_packet_data(store_rx_packet_data),
    .rx_packet_data(rx_packet_data)
  );

endmodule

`default_nettype wire

// ==== hdl/usb_rx_defs.svh ====
`ifndef USB_RX_DEFS_SVH
`define USB_RX_DEFS_SVH

// ******************************
// receiver sizing
// ******************************

// tb_clk cycles per usb bit, works from 4 to 16
`define USB_RX_OVERSAMPLE 8

// width of one payload or header byte
`define USB_RX_BYTE_WIDTH 8

// longest data payload accepted, crc bytes not counted
`define USB_RX_MAX_PAYLOAD 64

// ******************************
// crc residues
// ******************************

// register contents after a good token, crc field included
`define USB_RX_CRC5_RESIDUE 5'b01100

// register contents after a good data packet, crc field included
`define USB_RX_CRC16_RESIDUE 16'h800D

`endif

// ==== hdl/usb_rx_pkg.sv ====
`default_nettype none

`include "usb_rx_defs.svh"

package usb_rx_pkg;

  // ******************************
  // field types
  // ******************************

  typedef logic [`USB_RX_BYTE_WIDTH-1:0] byte_t;
  typedef logic [3:0] pid_t;
  typedef logic [4:0] crc5_t;
  typedef logic [15:0] crc16_t;

  // sync pattern kjkjkjkk, lsb-first after nrzi decode
  localparam byte_t SYNC_BYTE = 8'h80;

  // pid codes the receiver understands
  localparam pid_t PID_OUT = 4'b0001;
  localparam pid_t PID_IN = 4'b1001;
  localparam pid_t PID_DATA0 = 4'b0011;
  localparam pid_t PID_DATA1 = 4'b1011;
  localparam pid_t PID_ACK = 4'b0010;
  localparam pid_t PID_NAK = 4'b1010;

  // generator polynomials, top bit implied
  localparam crc5_t CRC5_POLY = 5'b00101;
  localparam crc16_t CRC16_POLY = 16'h8005;

  // ******************************
  // state and class encodings
  // ******************************

  // packet class seen by the consumer
  typedef enum logic [2:0] {
    RX_IDLE = 3'd0,
    RX_DATA = 3'd1,
    RX_OUT = 3'd2,
    RX_IN = 3'd3,
    RX_ACK = 3'd4,
    RX_NAK = 3'd5,
    RX_BAD = 3'd6
  } rx_packet_t;

  // line decoder
  typedef enum logic [1:0] {LINE_IDLE, LINE_RECEIVE, LINE_EOP} line_state_t;

  // packet decoder
  typedef enum logic [2:0] {
    ST_HUNT, ST_SYNC, ST_PID, ST_TOKEN, ST_PAYLOAD, ST_HANDSHAKE, ST_DONE, ST_ERROR
  } pkt_state_t;

endpackage

`default_nettype wire

// ==== tb/tb_usb_rx.sv ====
`default_nettype none

`include "usb_rx_defs.svh"

module tb_usb_rx;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int os = `USB_RX_OVERSAMPLE;
  localparam int clk_period = 40;
  localparam int max_payload = `USB_RX_MAX_PAYLOAD;
  // sync pattern as sent lsb first on the wire
  localparam logic [7:0] sync_byte = 8'h80;
  // pid codes from the usb spec
  localparam logic [3:0] pid_out = 4'b0001;
  localparam logic [3:0] pid_in = 4'b1001;
  localparam logic [3:0] pid_data0 = 4'b0011;
  localparam logic [3:0] pid_data1 = 4'b1011;
  localparam logic [3:0] pid_ack = 4'b0010;
  localparam logic [3:0] pid_nak = 4'b1010;
  localparam logic [3:0] pid_stall = 4'b1110;
  // corruption flags
  localparam int flip_crc = 1;
  localparam int no_stuff = 2;
  localparam int bad_comp = 4;
  localparam int extra_byte = 8;
  // packets in the test list
  localparam int test_packets = 25;
  // worst case bits per packet with stuffing and gap
  localparam int packet_bits = ((max_payload + 4) * 8 * 7) / 6 + 10;
  localparam int watchdog_ns = (test_packets * packet_bits + 64) * os * clk_period;

  logic tb_clk;
  logic arst_n;
  logic d_plus;
  logic d_minus;
  usb_rx_pkg::rx_packet_t rx_packet;
  logic store_rx_packet_data;
  usb_rx_pkg::byte_t rx_packet_data;

  integer seed;
  int errors = 0;
  int checks = 0;
  int packets_sent = 0;
  int packets_checked = 0;
  logic eop_seen;
  // current nrzi level where 1 is J
  logic line_j;
  usb_rx_pkg::byte_t exp_bytes[$];
  usb_rx_pkg::rx_packet_t exp_class[$];

  usb_rx i_dut (
    .tb_clk(tb_clk),
    .arst_n(arst_n),
    .d_plus(d_plus),
    .d_minus(d_minus),
    .rx_packet(rx_packet),
    .store_rx_packet_data(store_rx_packet_data),
    .rx_packet_data(rx_packet_data)
  );

  initial begin
    tb_clk = 1'b0;
    forever #(clk_period / 2) tb_clk = ~tb_clk;
  end

  // ******************************
  // reference model
  // ******************************

  // reflected crc5 with the result ready to send lsb first
  function automatic logic [4:0] crc5_of(input logic [10:0] bits);
    logic [4:0] crc;
    logic fb;
    crc = 5'h1F;
    for (int i = 0; i < 11; i++) begin
      fb = bits[i] ^ crc[0];
      crc = crc >> 1;
      if (fb) crc = crc ^ 5'h14;
    end
    return ~crc;
  endfunction

  // reflected crc16 over whole bytes
  function automatic logic [15:0] crc16_of(input usb_rx_pkg::byte_t data[$]);
    logic [15:0] crc;
    logic fb;
    crc = 16'hFFFF;
    foreach (data[i]) begin
      for (int k = 0; k < 8; k++) begin
        fb = data[i][k] ^ crc[0];
        crc = crc >> 1;
        if (fb) crc = crc ^ 16'hA001;
      end
    end
    return ~crc;
  endfunction

  // returns the expected class and queues the payload bytes for the strobes
  function automatic usb_rx_pkg::rx_packet_t predict_packet(
    input usb_rx_pkg::byte_t pid_byte,
    input usb_rx_pkg::byte_t body[$],
    input int flags
  );
    usb_rx_pkg::byte_t data[$];
    usb_rx_pkg::rx_packet_t cls;
    logic [15:0] field;
    logic [3:0] pid;
    int n;
    pid = pid_byte[3:0];
    n = body.size();
    cls = usb_rx_pkg::RX_BAD;
    if ((flags & no_stuff) == 0 && pid_byte[7:4] == ~pid) begin
      case (pid)
        pid_in, pid_out: begin
          // address, endpoint and crc5 in exactly two bytes
          if (n == 2) begin
            field = {body[1], body[0]};
            if (crc5_of(field[10:0]) == field[15:11]) begin
              cls = (pid == pid_in) ? usb_rx_pkg::RX_IN : usb_rx_pkg::RX_OUT;
            end
          end
        end
        pid_data0, pid_data1: begin
          if (n >= 2) begin
            for (int i = 0; i < n - 2; i++) begin
              data.push_back(body[i]);
            end
            // every byte ahead of the crc is strobed even with a bad crc
            for (int i = 0; i < n - 2 && i < max_payload; i++) begin
              exp_bytes.push_back(data[i]);
            end
            field = {body[n-1], body[n-2]};
            if (n - 2 <= max_payload && crc16_of(data) == field) begin
              cls = usb_rx_pkg::RX_DATA;
            end
          end
        end
        pid_ack, pid_nak: begin
          if (n == 0) begin
            cls = (pid == pid_ack) ? usb_rx_pkg::RX_ACK : usb_rx_pkg::RX_NAK;
          end
        end
        // stall and all other pids
        default: cls = usb_rx_pkg::RX_BAD;
      endcase
    end
    return cls;
  endfunction

  // ******************************
  // checks and run end
  // ******************************

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERROR %0t ns %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // outputs sampled on the falling edge
  always @(negedge tb_clk) begin
    if (!arst_n) begin
      eop_seen = 1'b0;
    end else begin
      if (store_rx_packet_data) begin
        if (exp_bytes.size() == 0) begin
          errors++;
          $display("%0t ns: a byte was strobed with no payload byte outstanding", $time);
        end else begin
          check_value("rx_packet_data", 32'(exp_bytes.pop_front()), 32'(rx_packet_data));
        end
      end
      // class lands one cycle after eop
      if (eop_seen) begin
        if (exp_class.size() == 0) begin
          errors++;
          $display("%0t ns: end of packet seen with no packet sent", $time);
        end else begin
          check_value("rx_packet", 32'(exp_class.pop_front()), 32'(rx_packet));
        end
        if (exp_bytes.size() != 0) begin
          errors++;
          $display("%0t ns: %0d payload bytes were never strobed", $time, exp_bytes.size());
          exp_bytes.delete();
        end
        packets_checked++;
      end
      eop_seen = i_dut.bits.eop;
    end
  end

  initial begin
    #(watchdog_ns);
    errors++;
    $display("watchdog expired, the tests did not complete in time");
    finish_run();
  end

  // ******************************
  // line driver
  // ******************************

  // one bit time of a line state starting at a rising edge
  task automatic hold_line(input logic dp, input logic dm);
    d_plus <= dp;
    d_minus <= dm;
    repeat (os) @(posedge tb_clk);
  endtask

  // nrzi where a zero toggles the line
  task automatic send_bit(input logic b);
    if (!b) line_j = ~line_j;
    hold_line(line_j, ~line_j);
  endtask

  task automatic wait_classified();
    int waited;
    waited = 0;
    while (packets_checked < packets_sent && waited < 4 * os) begin
      @(posedge tb_clk);
      waited++;
    end
    if (packets_checked < packets_sent) begin
      errors++;
      $display("%0t ns: packet %0d was never classified", $time, packets_sent);
      // drop what this packet left behind so the next one lines up
      exp_class.delete();
      exp_bytes.delete();
      packets_checked = packets_sent;
    end
  endtask

  task automatic send_packet(input usb_rx_pkg::byte_t pid_byte,
                             input usb_rx_pkg::byte_t body[$], input int flags);
    usb_rx_pkg::byte_t wire_bytes[$];
    int ones;
    logic b;
    exp_class.push_back(predict_packet(pid_byte, body, flags));
    packets_sent++;
    wire_bytes = body;
    wire_bytes.push_front(pid_byte);
    wire_bytes.push_front(sync_byte);
    ones = 0;
    foreach (wire_bytes[i]) begin
      for (int k = 0; k < 8; k++) begin
        b = wire_bytes[i][k];
        send_bit(b);
        ones = b ? ones + 1 : 0;
        // stuffed zero after six ones counted from the start of sync
        if (ones == 6 && (flags & no_stuff) == 0) begin
          send_bit(1'b0);
          ones = 0;
        end
      end
    end
    // eop is two bit times of se0 then j
    hold_line(1'b0, 1'b0);
    hold_line(1'b0, 1'b0);
    line_j = 1'b1;
    hold_line(1'b1, 1'b0);
    wait_classified();
  endtask

  // ******************************
  // packet builders
  // ******************************

  task automatic send_token(input logic [3:0] pid, input int flags);
    usb_rx_pkg::byte_t body[$];
    logic [31:0] rnd;
    logic [6:0] addr;
    logic [3:0] endp;
    logic [15:0] field;
    rnd = $random(seed);
    addr = rnd[6:0];
    endp = rnd[10:7];
    // all ones address runs past six ones
    if ((flags & no_stuff) != 0) addr = 7'h7F;
    field = {crc5_of({endp, addr}), endp, addr};
    if ((flags & flip_crc) != 0) field[13] = ~field[13];
    body.push_back(field[7:0]);
    body.push_back(field[15:8]);
    send_packet({~pid, pid}, body, flags);
  endtask

  task automatic send_data(input logic [3:0] pid, input int len, input logic all_ones,
                           input int flags);
    usb_rx_pkg::byte_t body[$];
    logic [31:0] rnd;
    logic [15:0] crc;
    for (int i = 0; i < len; i++) begin
      rnd = $random(seed);
      body.push_back(all_ones ? 8'hFF : rnd[7:0]);
    end
    crc = crc16_of(body);
    if ((flags & flip_crc) != 0) crc[0] = ~crc[0];
    body.push_back(crc[7:0]);
    body.push_back(crc[15:8]);
    send_packet({~pid, pid}, body, flags);
  endtask

  task automatic send_handshake(input logic [3:0] pid, input int flags);
    usb_rx_pkg::byte_t body[$];
    usb_rx_pkg::byte_t pid_byte;
    logic [31:0] rnd;
    pid_byte = {~pid, pid};
    if ((flags & bad_comp) != 0) pid_byte[4] = ~pid_byte[4];
    if ((flags & extra_byte) != 0) begin
      rnd = $random(seed);
      body.push_back(rnd[7:0]);
    end
    send_packet(pid_byte, body, flags);
  endtask

  // ******************************
  // test sequence
  // ******************************

  initial begin
    int len;
    seed = 4874;
    line_j = 1'b1;
    arst_n = 1'b0;
    d_plus = 1'b1;
    d_minus = 1'b0;
    repeat (8) @(posedge tb_clk);
    arst_n <= 1'b1;
    // idle line where any strobe is flagged
    repeat (4 * os) @(posedge tb_clk);
    @(negedge tb_clk);
    check_value("rx_packet", 32'(usb_rx_pkg::RX_IDLE), 32'(rx_packet));
    @(posedge tb_clk);
    // tokens
    send_token(pid_in, 0);
    send_token(pid_out, 0);
    send_token(pid_in, 0);
    send_token(pid_out, 0);
    send_token(pid_in, flip_crc);
    send_token(pid_out, no_stuff);
    // data with edge lengths then random ones
    send_data(pid_data0, 0, 1'b0, 0);
    send_data(pid_data1, 1, 1'b0, 0);
    send_data(pid_data0, max_payload, 1'b0, 0);
    for (int i = 0; i < 8; i++) begin
      len = $unsigned($random(seed)) % (max_payload + 1);
      send_data((i % 2 == 1) ? pid_data1 : pid_data0, len, 1'b0, 0);
    end
    // stuffing on every byte
    send_data(pid_data1, max_payload, 1'b1, 0);
    send_data(pid_data0, 7, 1'b1, 0);
    // good and bad handshakes
    send_handshake(pid_ack, 0);
    send_handshake(pid_nak, 0);
    send_handshake(pid_stall, 0);
    send_handshake(pid_ack, bad_comp);
    send_handshake(pid_nak, extra_byte);
    // bad crc16 where the bytes are still strobed
    send_data(pid_data1, 20, 1'b0, flip_crc);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/usb_rx_pkg.sv
hdl/usb_bit_if.sv
hdl/usb_crc.sv
hdl/usb_line_decoder.sv
hdl/usb_packet_decoder.sv
hdl/usb_rx.sv
tb/tb_usb_rx.sv
